/* verilog/clock_pkg.sv */
package clock_pkg;

	// --------------------------------------------------
	// field and display types
	// --------------------------------------------------
	typedef logic [5:0] time_field_t;	// one of hr / min / sec, 0..59
	typedef logic [3:0] digit_t;	// bcd digit
	typedef logic [6:0] seg_t;	// {a, b, c, d, e, f, g}, active high
	typedef logic [5:0] digit_enb_t;	// active low, bit 0 = rightmost

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_t;

	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HR  = 2'd2
	} pos_t;

	// wrap limits
	localparam time_field_t SEC_MAX = 6'd59;
	localparam time_field_t MIN_MAX = 6'd59;
	localparam time_field_t HR_MAX  = 6'd23;

	localparam int NUM_DIGITS = 6;

	// segment codes for 0..9
	localparam seg_t SEG_BLANK = 7'b000_0000;
	localparam seg_t SEG_CODE [10] = '{
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
		7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_0011
	};

	// divider ratios for a 50 MHz clk
	localparam int SEC_DIV_DEF  = 50_000_000;	// 1 Hz
	localparam int SCAN_DIV_DEF = 5_000;	// 10 kHz digit scan
	localparam int DEB_DIV_DEF  = 500_000;	// 100 Hz button sample

	// +1 with wrap at lim, no carry out
	function automatic time_field_t field_inc(input time_field_t v, input time_field_t lim);
		if (v >= lim)
			return '0;
		return v + 6'd1;
	endfunction

endpackage

/* verilog/tick_gen.sv */
`timescale 1ns/1ps

module tick_gen #(
	parameter int DIV = 2
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CW-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else begin
			o_tick <= 1'b0;
			if (cnt == CW'(DIV - 1)) begin	// wrap, one strobe per DIV cycles
				cnt    <= '0;
				o_tick <= 1'b1;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	generate
		if (DIV > 1) begin : g_tick_chk
			a_tick_single : assert property (@(posedge clk) disable iff (!rst_n)
				o_tick |=> !o_tick)
				else $error("tick_gen: strobe high two cycles in a row");
		end
	endgenerate

endmodule

/* verilog/btn_sync.sv */
`timescale 1ns/1ps

module btn_sync (
	input  logic clk,
	input  logic rst_n,
	input  logic i_sample,
	input  logic i_btn_mode,
	input  logic i_btn_pos,
	input  logic i_btn_inc,
	input  logic i_btn_alarm,
	output logic o_press_mode,
	output logic o_press_pos,
	output logic o_press_inc,
	output logic o_press_alarm
);

	logic [3:0] btn;
	logic [3:0] smp_new;	// latest sample
	logic [3:0] smp_old;	// sample before that
	logic [3:0] press;

	assign btn = {i_btn_mode, i_btn_pos, i_btn_inc, i_btn_alarm};

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			smp_new <= '0;
			smp_old <= '0;
		end else if (i_sample) begin
			smp_new <= btn;
			smp_old <= smp_new;
		end
	end

	// rising edge between two samples, one clk wide
	assign press = {4{i_sample}} & smp_new & ~smp_old;

	assign {o_press_mode, o_press_pos, o_press_inc, o_press_alarm} = press;

endmodule

/* verilog/mode_ctrl.sv */
`timescale 1ns/1ps

module mode_ctrl (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_press_mode,
	input  logic             i_press_pos,
	input  logic             i_press_inc,
	input  logic             i_press_alarm,
	output clock_pkg::mode_t o_mode,
	output logic             o_alarm_en,
	output logic             o_set_sec,
	output logic             o_set_min,
	output logic             o_set_hr,
	output logic             o_alm_sec,
	output logic             o_alm_min,
	output logic             o_alm_hr
);

	import clock_pkg::*;

	pos_t pos;
	logic inc_setup;
	logic inc_alarm;

	// --------------------------------------------------
	// mode fsm, position, alarm enable
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_mode     <= MODE_CLOCK;
			pos        <= POS_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			if (i_press_mode) begin
				case (o_mode)
					MODE_CLOCK: o_mode <= MODE_SETUP;
					MODE_SETUP: o_mode <= MODE_ALARM;
					default:    o_mode <= MODE_CLOCK;
				endcase
			end
			if (i_press_pos) begin
				case (pos)
					POS_SEC: pos <= POS_MIN;
					POS_MIN: pos <= POS_HR;
					default: pos <= POS_SEC;
				endcase
			end
			if (i_press_alarm)
				o_alarm_en <= ~o_alarm_en;
		end
	end

	// route the inc press to one field
	assign inc_setup = i_press_inc && (o_mode == MODE_SETUP);
	assign inc_alarm = i_press_inc && (o_mode == MODE_ALARM);

	assign o_set_sec = inc_setup && (pos == POS_SEC);
	assign o_set_min = inc_setup && (pos == POS_MIN);
	assign o_set_hr  = inc_setup && (pos == POS_HR);
	assign o_alm_sec = inc_alarm && (pos == POS_SEC);
	assign o_alm_min = inc_alarm && (pos == POS_MIN);
	assign o_alm_hr  = inc_alarm && (pos == POS_HR);

	a_inc_onehot : assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({o_set_sec, o_set_min, o_set_hr, o_alm_sec, o_alm_min, o_alm_hr}))
		else $error("mode_ctrl: more than one increment active");

endmodule

/* verilog/time_counter.sv */
`timescale 1ns/1ps

module time_counter (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_tick,
	input  clock_pkg::mode_t       i_mode,
	input  logic                   i_set_sec,
	input  logic                   i_set_min,
	input  logic                   i_set_hr,
	output clock_pkg::time_field_t o_sec,
	output clock_pkg::time_field_t o_min,
	output clock_pkg::time_field_t o_hr
);

	import clock_pkg::*;

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_sec <= '0;
			o_min <= '0;
			o_hr  <= '0;
		end else if (i_mode == MODE_SETUP) begin
			// time frozen, each field wraps on its own
			if (i_set_sec)
				o_sec <= field_inc(o_sec, SEC_MAX);
			if (i_set_min)
				o_min <= field_inc(o_min, MIN_MAX);
			if (i_set_hr)
				o_hr <= field_inc(o_hr, HR_MAX);
		end else if (i_tick) begin
			o_sec <= field_inc(o_sec, SEC_MAX);
			if (o_sec == SEC_MAX) begin	// carry into min
				o_min <= field_inc(o_min, MIN_MAX);
				if (o_min == MIN_MAX)	// carry into hr, 23:59:59 -> 0
					o_hr <= field_inc(o_hr, HR_MAX);
			end
		end
	end

	a_field_range : assert property (@(posedge clk) disable iff (!rst_n)
		(o_sec <= SEC_MAX) && (o_min <= MIN_MAX) && (o_hr <= HR_MAX))
		else $error("time_counter: field out of range %0d:%0d:%0d", o_hr, o_min, o_sec);

endmodule

/* verilog/alarm_unit.sv */
`timescale 1ns/1ps

module alarm_unit (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_alarm_en,
	input  logic                   i_alm_sec,
	input  logic                   i_alm_min,
	input  logic                   i_alm_hr,
	input  clock_pkg::time_field_t i_sec,
	input  clock_pkg::time_field_t i_min,
	input  clock_pkg::time_field_t i_hr,
	output clock_pkg::time_field_t o_alm_sec,
	output clock_pkg::time_field_t o_alm_min,
	output clock_pkg::time_field_t o_alm_hr,
	output logic                   o_alarm
);

	import clock_pkg::*;

	logic match;

	// alarm setting with no carry between fields
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			o_alm_sec <= '0;
			o_alm_min <= '0;
			o_alm_hr  <= '0;
		end else begin
			if (i_alm_sec)
				o_alm_sec <= field_inc(o_alm_sec, SEC_MAX);
			if (i_alm_min)
				o_alm_min <= field_inc(o_alm_min, MIN_MAX);
			if (i_alm_hr)
				o_alm_hr <= field_inc(o_alm_hr, HR_MAX);
		end
	end

	assign match = (i_sec == o_alm_sec) && (i_min == o_alm_min) && (i_hr == o_alm_hr);

	// sticky until the enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0)
			o_alarm <= 1'b0;
		else
			o_alarm <= i_alarm_en & (match | o_alarm);
	end

endmodule

/* verilog/seg_scan.sv */
`timescale 1ns/1ps

module seg_scan (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_scan,
	input  clock_pkg::mode_t       i_mode,
	input  clock_pkg::time_field_t i_sec,
	input  clock_pkg::time_field_t i_min,
	input  clock_pkg::time_field_t i_hr,
	input  clock_pkg::time_field_t i_alm_sec,
	input  clock_pkg::time_field_t i_alm_min,
	input  clock_pkg::time_field_t i_alm_hr,
	output clock_pkg::seg_t        o_seg,
	output clock_pkg::digit_enb_t  o_seg_enb
);

	import clock_pkg::*;

	localparam int IDX_W = $clog2(NUM_DIGITS);

	time_field_t      show_sec;
	time_field_t      show_min;
	time_field_t      show_hr;
	digit_t           digits [NUM_DIGITS];
	logic [IDX_W-1:0] idx;
	logic [IDX_W-1:0] idx_nxt;
	logic [IDX_W-1:0] idx_sel;

	function automatic seg_t seg_decode(input digit_t d);
		if (d <= 4'd9)
			return SEG_CODE[d];
		return SEG_BLANK;	// not a bcd digit
	endfunction

	// --------------------------------------------------
	// shown value and digit split
	// --------------------------------------------------
	always_comb begin
		show_sec = (i_mode == MODE_ALARM) ? i_alm_sec : i_sec;
		show_min = (i_mode == MODE_ALARM) ? i_alm_min : i_min;
		show_hr  = (i_mode == MODE_ALARM) ? i_alm_hr  : i_hr;
		digits[0] = digit_t'(show_sec % 6'd10);
		digits[1] = digit_t'(show_sec / 6'd10);
		digits[2] = digit_t'(show_min % 6'd10);
		digits[3] = digit_t'(show_min / 6'd10);
		digits[4] = digit_t'(show_hr % 6'd10);
		digits[5] = digit_t'(show_hr / 6'd10);
	end

	// --------------------------------------------------
	// scan index and registered outputs
	// --------------------------------------------------
	assign idx_nxt = (idx == IDX_W'(NUM_DIGITS - 1)) ? '0 : idx + 1'b1;
	assign idx_sel = i_scan ? idx_nxt : idx;	// outputs follow the index

	always_ff @(posedge clk or negedge rst_n) begin
		if (rst_n == 1'b0) begin
			idx       <= '0;
			o_seg     <= SEG_BLANK;
			o_seg_enb <= ~digit_enb_t'(1);	// digit 0 on
		end else begin
			idx       <= idx_sel;
			o_seg     <= seg_decode(digits[idx_sel]);
			o_seg_enb <= ~(digit_enb_t'(1) << idx_sel);
		end
	end

endmodule

/* verilog/digital_clock_top.sv */
`timescale 1ns/1ps

module digital_clock_top #(
	parameter int SEC_DIV  = clock_pkg::SEC_DIV_DEF,
	parameter int SCAN_DIV = clock_pkg::SCAN_DIV_DEF,
	parameter int DEB_DIV  = clock_pkg::DEB_DIV_DEF
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_btn_mode,
	input  logic                  i_btn_pos,
	input  logic                  i_btn_inc,
	input  logic                  i_btn_alarm,
	output clock_pkg::seg_t       o_seg,
	output clock_pkg::digit_enb_t o_seg_enb,
	output logic                  o_alarm
);

	import clock_pkg::*;

	logic        sec_tick, scan_tick, sample_tick;
	logic        press_mode, press_pos, press_inc, press_alarm;
	mode_t       mode;
	logic        alarm_en;
	logic        set_sec, set_min, set_hr;
	logic        alm_inc_sec, alm_inc_min, alm_inc_hr;
	time_field_t sec, min, hr;
	time_field_t alm_sec, alm_min, alm_hr;

	// --------------------------------------------------
	// strobes
	// --------------------------------------------------
	tick_gen #(.DIV(SEC_DIV)) u_sec_tick (
		.clk(clk), .rst_n(rst_n), .o_tick(sec_tick));

	tick_gen #(.DIV(SCAN_DIV)) u_scan_tick (
		.clk(clk), .rst_n(rst_n), .o_tick(scan_tick));

	tick_gen #(.DIV(DEB_DIV)) u_sample_tick (
		.clk(clk), .rst_n(rst_n), .o_tick(sample_tick));

	// --------------------------------------------------
	// control and counters
	// --------------------------------------------------
	btn_sync u_btn_sync (
		.clk(clk), .rst_n(rst_n), .i_sample(sample_tick),
		.i_btn_mode(i_btn_mode), .i_btn_pos(i_btn_pos),
		.i_btn_inc(i_btn_inc), .i_btn_alarm(i_btn_alarm),
		.o_press_mode(press_mode), .o_press_pos(press_pos),
		.o_press_inc(press_inc), .o_press_alarm(press_alarm));

	mode_ctrl u_mode_ctrl (
		.clk(clk), .rst_n(rst_n),
		.i_press_mode(press_mode), .i_press_pos(press_pos),
		.i_press_inc(press_inc), .i_press_alarm(press_alarm),
		.o_mode(mode), .o_alarm_en(alarm_en),
		.o_set_sec(set_sec), .o_set_min(set_min), .o_set_hr(set_hr),
		.o_alm_sec(alm_inc_sec), .o_alm_min(alm_inc_min), .o_alm_hr(alm_inc_hr));

	time_counter u_time_counter (
		.clk(clk), .rst_n(rst_n), .i_tick(sec_tick), .i_mode(mode),
		.i_set_sec(set_sec), .i_set_min(set_min), .i_set_hr(set_hr),
		.o_sec(sec), .o_min(min), .o_hr(hr));

	alarm_unit u_alarm_unit (
		.clk(clk), .rst_n(rst_n), .i_alarm_en(alarm_en),
		.i_alm_sec(alm_inc_sec), .i_alm_min(alm_inc_min), .i_alm_hr(alm_inc_hr),
		.i_sec(sec), .i_min(min), .i_hr(hr),
		.o_alm_sec(alm_sec), .o_alm_min(alm_min), .o_alm_hr(alm_hr),
		.o_alarm(o_alarm));

	seg_scan u_seg_scan (
		.clk(clk), .rst_n(rst_n), .i_scan(scan_tick), .i_mode(mode),
		.i_sec(sec), .i_min(min), .i_hr(hr),
		.i_alm_sec(alm_sec), .i_alm_min(alm_min), .i_alm_hr(alm_hr),
		.o_seg(o_seg), .o_seg_enb(o_seg_enb));

endmodule

/* dv/display_checker.sv */
`timescale 1ns/1ps

module display_checker (
	input  logic       clk,
	input  logic [6:0] i_seg,
	input  logic [5:0] i_seg_enb,
	input  logic       i_alarm,
	input  logic       i_req,
	input  int         i_exp_hr,
	input  int         i_exp_min,
	input  int         i_exp_sec,
	input  logic       i_exp_alarm,
	output logic       o_done,
	output logic       o_ok
);

	int n_chk = 0;

	// segments {a..g} back to a digit, -1 if not a digit
	function automatic int seg_to_digit(input logic [6:0] s);
		case (s)
			7'b111_1110: return 0;
			7'b011_0000: return 1;
			7'b110_1101: return 2;
			7'b111_1001: return 3;
			7'b011_0011: return 4;
			7'b101_1011: return 5;
			7'b101_1111: return 6;
			7'b111_0000: return 7;
			7'b111_1111: return 8;
			7'b111_0011: return 9;
			default:     return -1;
		endcase
	endfunction

	// one full scan, digit 0 first
	task automatic grab_scan(output int hr, output int mn, output int sc, output logic bad);
		int d [6];
		int i;
		bad = 1'b0;
		@(negedge clk);
		while (i_seg_enb != 6'b111110)
			@(negedge clk);
		for (i = 0; i < 6; i++) begin
			while (i_seg_enb != ~(6'b000001 << i))
				@(negedge clk);
			d[i] = seg_to_digit(i_seg);
			if (d[i] < 0) begin
				$display("%0t: digit %0d shows segment code %b, which is no digit",
					$time, i, i_seg);
				bad = 1'b1;
			end
		end
		hr = d[5] * 10 + d[4];
		mn = d[3] * 10 + d[2];
		sc = d[1] * 10 + d[0];
	endtask

	initial begin
		o_done = 1'b0;
		o_ok   = 1'b0;
	end

	// --------------------------------------------------
	// compare up to three scans per request
	// --------------------------------------------------
	always begin : check_loop
		int   hr;
		int   mn;
		int   sc;
		int   tries;
		logic bad;
		logic ok;
		wait (i_req == 1'b1);
		n_chk++;
		ok = 1'b0;
		for (tries = 0; tries < 3 && !ok; tries++) begin
			grab_scan(hr, mn, sc, bad);
			if (!bad && hr == i_exp_hr && mn == i_exp_min && sc == i_exp_sec &&
				i_alarm == i_exp_alarm)
				ok = 1'b1;
		end
		if (ok) begin
			$display("check %0d pass  %02d:%02d:%02d alarm %0b", n_chk, hr, mn, sc, i_alarm);
		end else begin
			if (hr != i_exp_hr || mn != i_exp_min || sc != i_exp_sec)
				$display("[FAIL] %0t o_seg expected %02d:%02d:%02d got %02d:%02d:%02d",
					$time, i_exp_hr, i_exp_min, i_exp_sec, hr, mn, sc);
			if (i_alarm != i_exp_alarm)
				$display("[FAIL] %0t o_alarm expected %0b got %0b",
					$time, i_exp_alarm, i_alarm);
			$display("check %0d fail", n_chk);
		end
		o_ok   = ok;
		o_done = 1'b1;
		wait (i_req == 1'b0);
		@(negedge clk);
		o_done = 1'b0;
	end

endmodule

/* dv/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

	localparam int SEC_DIV    = 2000;
	localparam int SCAN_DIV   = 8;
	localparam int DEB_DIV    = 16;
	localparam int PRESS_CYC  = 8 * DEB_DIV;	// 4 periods down and 4 up
	localparam int CHECK_CYC  = 400;	// each check takes this many cycles
	localparam int SETTLE_CYC = SEC_DIV / 2;	// keeps checks away from tick edges
	localparam int MARGIN_CYC = 200;

	logic       clk;
	logic       rst_n;
	logic       btn_mode;
	logic       btn_pos;
	logic       btn_inc;
	logic       btn_alarm;
	logic [6:0] seg;
	logic [5:0] seg_enb;
	logic       alarm;
	logic       chk_req;
	logic       chk_done;
	logic       chk_ok;
	logic       exp_alarm;
	int         exp_hr;
	int         exp_min;
	int         exp_sec;

	byte cmd_kind [$];
	byte cmd_btn [$];
	int  cmd_a [$];
	int  cmd_b [$];
	int  cmd_c [$];
	int  cmd_d [$];
	int  budget_cyc = 0;
	int  n_pass = 0;
	int  n_fail = 0;

	always #4 clk = ~clk;

	digital_clock_top #(
		.SEC_DIV(SEC_DIV), .SCAN_DIV(SCAN_DIV), .DEB_DIV(DEB_DIV)
	) dut_i (
		.clk(clk), .rst_n(rst_n),
		.i_btn_mode(btn_mode), .i_btn_pos(btn_pos),
		.i_btn_inc(btn_inc), .i_btn_alarm(btn_alarm),
		.o_seg(seg), .o_seg_enb(seg_enb), .o_alarm(alarm));

	display_checker u_checker (
		.clk(clk), .i_seg(seg), .i_seg_enb(seg_enb), .i_alarm(alarm),
		.i_req(chk_req), .i_exp_hr(exp_hr), .i_exp_min(exp_min),
		.i_exp_sec(exp_sec), .i_exp_alarm(exp_alarm),
		.o_done(chk_done), .o_ok(chk_ok));

	// n edges and 1 ns past the last one
	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic load_golden();
		int    fd;
		int    a;
		int    b;
		int    c;
		int    d;
		byte   k;
		byte   w;
		string line;
		fd = $fopen("dv/clock_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open dv/clock_golden.txt");
			n_fail++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue;
			void'($sscanf(line, "%c", k));
			a = 0;
			b = 0;
			c = 0;
			d = 0;
			w = " ";
			case (k)
				"P": void'($sscanf(line, "%c %c %d", k, w, a));
				"W": void'($sscanf(line, "%c %d", k, a));
				"C": void'($sscanf(line, "%c %d %d %d %d", k, a, b, c, d));
				default: begin
					$display("golden file line not understood: %s", line);
					n_fail++;
					continue;
				end
			endcase
			cmd_kind.push_back(k);
			cmd_btn.push_back(w);
			cmd_a.push_back(a);
			cmd_b.push_back(b);
			cmd_c.push_back(c);
			cmd_d.push_back(d);
		end
		$fclose(fd);
	endtask

	task automatic set_btn(input byte which, input logic v);
		case (which)
			"M": btn_mode = v;
			"S": btn_pos = v;
			"I": btn_inc = v;
			"A": btn_alarm = v;
			default: begin
				$display("unknown button %c in golden file", which);
				n_fail++;
			end
		endcase
	endtask

	task automatic press(input byte which, input int count);
		repeat (count) begin
			set_btn(which, 1'b1);
			step(4 * DEB_DIV);
			set_btn(which, 1'b0);
			step(4 * DEB_DIV);
		end
	endtask

	task automatic run_check(input int h, input int m, input int s, input int a);
		int n;
		wait (chk_done == 1'b0);
		exp_hr    = h;
		exp_min   = m;
		exp_sec   = s;
		exp_alarm = a[0];
		chk_req   = 1'b1;
		n = 0;
		while (!chk_done) begin
			step(1);
			n++;
		end
		chk_req = 1'b0;
		if (chk_ok)
			n_pass++;
		else
			n_fail++;
		if (n < CHECK_CYC)
			step(CHECK_CYC - n);
	endtask

	// --------------------------------------------------
	// watchdog
	// --------------------------------------------------
	initial begin
		wait (budget_cyc > 0);
		repeat (budget_cyc) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", budget_cyc);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int i;
		int total;
		clk       = 1'b0;
		rst_n     = 1'b0;
		btn_mode  = 1'b0;
		btn_pos   = 1'b0;
		btn_inc   = 1'b0;
		btn_alarm = 1'b0;
		chk_req   = 1'b0;
		exp_hr    = 0;
		exp_min   = 0;
		exp_sec   = 0;
		exp_alarm = 1'b0;
		load_golden();
		total = 2 + SETTLE_CYC + MARGIN_CYC;
		for (i = 0; i < cmd_kind.size(); i++) begin
			case (cmd_kind[i])
				"P": total += cmd_a[i] * (PRESS_CYC + 8);
				"W": total += cmd_a[i] * SEC_DIV;
				default: total += 2 * CHECK_CYC;
			endcase
		end
		budget_cyc = total;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		step(SETTLE_CYC);
		for (i = 0; i < cmd_kind.size(); i++) begin
			case (cmd_kind[i])
				"P": press(cmd_btn[i], cmd_a[i]);
				"W": if (cmd_a[i] > 0) step(cmd_a[i] * SEC_DIV);
				default: run_check(cmd_a[i], cmd_b[i], cmd_c[i], cmd_d[i]);
			endcase
		end
		$display("checks passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0 && n_pass > 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* dv/clock_golden.txt */
# P <button M|S|I|A> <count>   W <seconds>   C <hh> <mm> <ss> <alarm>
# button M = mode, S = position, I = increment, A = alarm enable
C 0 0 0 0
W 61
C 0 1 1 0
P M 1
C 0 1 1 0
W 2
C 0 1 1 0
P I 58
C 0 1 59 0
P I 1
C 0 1 0 0
P S 1
P I 58
P S 1
P I 23
P S 1
P I 59
P S 6
C 23 59 59 0
P M 2
C 23 59 59 0
W 1
C 0 0 0 0
P M 2
P I 5
C 0 0 5 0
P M 1
C 0 0 1 0
P A 1
W 2
C 0 0 3 0
P S 3
C 0 0 4 0
W 2
C 0 0 6 1
P A 1
C 0 0 6 0

/* flist.f */
verilog/clock_pkg.sv
verilog/tick_gen.sv
verilog/btn_sync.sv
verilog/mode_ctrl.sv
verilog/time_counter.sv
verilog/alarm_unit.sv
verilog/seg_scan.sv
verilog/digital_clock_top.sv
dv/display_checker.sv
dv/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the clock testbench with Verilator, from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_top -f flist.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
grep -q "TEST OK" sim.log
